//--- Makefile
SOURCES := $(filter-out +%,$(shell cat sim.f))

.PHONY: run clean

run: obj_dir/Vafu_tb
	./obj_dir/Vafu_tb > sim.log 2>&1; cat sim.log
	@grep -q "All tests passed" sim.log
	@! grep -q "Some tests failed" sim.log

obj_dir/Vafu_tb: sim.f $(SOURCES) design/afu_settings.svh
	verilator --binary --timing --top-module afu_tb -f sim.f -o Vafu_tb

clean:
	rm -rf obj_dir sim.log

//--- design/afu_pkg.sv
`include "afu_settings.svh"

package afu_pkg;

  typedef logic [`AFU_ADDR_BITS-1:0] addr_t;
  typedef logic [`AFU_COUNT_BITS-1:0] count_t;
  typedef logic [`AFU_TAG_BITS-1:0] tag_t;
  typedef logic [`AFU_HALF_BITS-1:0] half_t;
  typedef logic [7:0] cu_id_t;

  // This unit has a single compute unit.
  localparam cu_id_t cu_id_self = 8'h02;

  typedef enum logic [7:0] {
    invalid  = 8'h00,
    write_ms = 8'h20  // Write of a full line to host memory.
  } command_e;

  typedef enum logic [1:0] {
    cmd_invalid = 2'b00,
    cmd_write   = 2'b01
  } cmd_type_e;

  typedef enum logic [1:0] {
    resp_done   = 2'b00,
    resp_failed = 2'b01
  } resp_code_e;

  // Validity of a command travels beside it on its own wire.
  typedef struct packed {
    command_e    command;
    cmd_type_e   cmd_type;
    addr_t       address;
    logic [11:0] size;
    cu_id_t      cu_id;
  } command_line_t;

  // Lower half of the line in data_0, upper half in data_1.
  typedef struct packed {
    cu_id_t    cu_id;
    cmd_type_e cmd_type;
    half_t     data_0;
    half_t     data_1;
  } data_line_t;

endpackage

//--- design/afu_settings.svh
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// Host interface widths.
`define AFU_ADDR_BITS 64
`define AFU_HALF_BITS 512
`define AFU_TAG_BITS 8
`define AFU_COUNT_BITS 16

// Each internal buffer starts with this many credits held upstream.
`define AFU_BUF_DEPTH 4
`define AFU_HOST_CREDITS 2

// A result line is two data halves, written as one command.
`define AFU_LINE_BYTES 128
`define AFU_RESULT_OFFSET 128

`endif

//--- design/afu_top.sv
module afu_top (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled,
  input  logic                   wed_valid,
  input  afu_pkg::addr_t         wed_address,
  input  afu_pkg::count_t        wed_count,
  input  logic                   host_credit,
  input  logic                   resp_valid,
  input  afu_pkg::tag_t          resp_tag,
  input  afu_pkg::resp_code_e    resp_code,
  output logic                   busy,
  output logic                   host_cmd_valid,
  output afu_pkg::command_line_t host_cmd,
  output afu_pkg::tag_t          host_cmd_tag,
  output afu_pkg::data_line_t    host_data,
  output logic                   job_done,
  output afu_pkg::count_t        failed_count
);

  import afu_pkg::*;

  // resp_tag is visible at the top for host-side tracing only.

  logic          push;
  logic          pop;
  logic          credit_return;
  logic          cmd_not_empty;
  logic          job_start;
  count_t        job_count;
  command_line_t cmd_line;
  command_line_t cmd_head;
  data_line_t    data_line;
  data_line_t    data_head;

  cu_control u_cu_control (
    .clock         (clock),
    .rstn          (rstn),
    .enabled       (enabled),
    .wed_valid     (wed_valid),
    .wed_address   (wed_address),
    .wed_count     (wed_count),
    .credit_return (credit_return),
    .job_done      (job_done),
    .busy          (busy),
    .push          (push),
    .cmd_line      (cmd_line),
    .data_line     (data_line),
    .job_start     (job_start),
    .job_count     (job_count)
  );

  cmd_buffer #(.payload_t(command_line_t)) u_cmd_buf (
    .clock         (clock),
    .rstn          (rstn),
    .push          (push),
    .push_data     (cmd_line),
    .pop           (pop),
    .pop_data      (cmd_head),
    .not_empty     (cmd_not_empty),
    .credit_return (credit_return)
  );

  // Pushed and popped in step with the command buffer.
  cmd_buffer #(.payload_t(data_line_t)) u_data_buf (
    .clock         (clock),
    .rstn          (rstn),
    .push          (push),
    .push_data     (data_line),
    .pop           (pop),
    .pop_data      (data_head),
    .not_empty     (),
    .credit_return ()
  );

  cmd_issue u_cmd_issue (
    .clock          (clock),
    .rstn           (rstn),
    .cmd_not_empty  (cmd_not_empty),
    .cmd_head       (cmd_head),
    .data_head      (data_head),
    .host_credit    (host_credit),
    .pop            (pop),
    .host_cmd_valid (host_cmd_valid),
    .host_cmd       (host_cmd),
    .host_cmd_tag   (host_cmd_tag),
    .host_data      (host_data)
  );

  resp_tracker u_resp_tracker (
    .clock        (clock),
    .rstn         (rstn),
    .job_start    (job_start),
    .job_count    (job_count),
    .resp_valid   (resp_valid),
    .resp_code    (resp_code),
    .job_done     (job_done),
    .failed_count (failed_count)
  );

endmodule

//--- design/cmd_buffer.sv
`include "afu_settings.svh"

module cmd_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     rstn,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     credit_return
);

  localparam int depth = `AFU_BUF_DEPTH;
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int fill_bits = $clog2(depth + 1);

  payload_t             mem [depth];
  logic [ptr_bits-1:0]  wr_ptr;
  logic [ptr_bits-1:0]  rd_ptr;
  logic [fill_bits-1:0] fill;

  function automatic logic [ptr_bits-1:0] ptr_next(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Upstream credits keep the fill level within depth.
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;  // One credit back per entry freed.
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
    end
  end

  assign pop_data  = mem[rd_ptr];
  assign not_empty = (fill != '0);

endmodule

//--- design/cmd_issue.sv
`include "afu_settings.svh"

module cmd_issue (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   cmd_not_empty,
  input  afu_pkg::command_line_t cmd_head,
  input  afu_pkg::data_line_t    data_head,
  input  logic                   host_credit,
  output logic                   pop,
  output logic                   host_cmd_valid,
  output afu_pkg::command_line_t host_cmd,
  output afu_pkg::tag_t          host_cmd_tag,
  output afu_pkg::data_line_t    host_data
);

  import afu_pkg::*;

  localparam int credit_bits = $clog2(`AFU_HOST_CREDITS + 1);

  logic [credit_bits-1:0] credits;
  tag_t                   next_tag;

  // Both buffers always hold the same number of entries.
  // The command buffer alone decides when a line is ready.
  assign pop = cmd_not_empty && (credits != '0);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credits        <= credit_bits'(`AFU_HOST_CREDITS);
      next_tag       <= '0;
      host_cmd_valid <= 1'b0;
    end else begin
      host_cmd_valid <= pop;
      if (pop) begin
        next_tag <= next_tag + 1'b1;  // Wraps with the tag width.
      end
      if (pop && !host_credit) begin
        credits <= credits - 1'b1;
      end else if (host_credit && !pop) begin
        credits <= credits + 1'b1;
      end
    end
  end

  // Host port holds the last issued line until the next issue.
  always_ff @(posedge clock) begin
    if (pop) begin
      host_cmd     <= cmd_head;
      host_data    <= data_head;
      host_cmd_tag <= next_tag;
    end
  end

endmodule

//--- design/cu_control.sv
`include "afu_settings.svh"

module cu_control (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled,
  input  logic                   wed_valid,
  input  afu_pkg::addr_t         wed_address,
  input  afu_pkg::count_t        wed_count,
  input  logic                   credit_return,
  input  logic                   job_done,
  output logic                   busy,
  output logic                   push,
  output afu_pkg::command_line_t cmd_line,
  output afu_pkg::data_line_t    data_line,
  output logic                   job_start,
  output afu_pkg::count_t        job_count
);

  import afu_pkg::*;

  localparam int credit_bits = $clog2(`AFU_BUF_DEPTH + 1);
  localparam int words = `AFU_HALF_BITS / 64;

  logic                   accept;
  logic                   busy_r;
  logic                   generating;
  count_t                 index;
  addr_t                  line_addr;
  logic [credit_bits-1:0] credits;

  // Busy drops in the cycle job_done pulses, so a new WED may be taken then.
  assign busy   = busy_r && !job_done;
  assign accept = wed_valid && enabled && !busy;
  assign push   = generating && (credits != '0);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy_r     <= 1'b0;
      job_start  <= 1'b0;
      generating <= 1'b0;
      index      <= '0;
      credits    <= credit_bits'(`AFU_BUF_DEPTH);
    end else begin
      job_start <= accept;
      if (accept) begin
        busy_r <= 1'b1;
      end else if (job_done) begin
        busy_r <= 1'b0;
      end
      if (accept) begin
        generating <= (wed_count != '0);
        index      <= '0;
      end else if (push) begin
        index <= index + 1'b1;
        if (index == job_count - 1'b1) begin
          generating <= 1'b0;  // Last line of the job has gone out.
        end
      end
      if (push && !credit_return) begin
        credits <= credits - 1'b1;
      end else if (credit_return && !push) begin
        credits <= credits + 1'b1;
      end
    end
  end

  // Descriptor fields and the running line address.
  always_ff @(posedge clock) begin
    if (accept) begin
      job_count <= wed_count;
      line_addr <= wed_address + addr_t'(`AFU_RESULT_OFFSET);
    end else if (push) begin
      line_addr <= line_addr + addr_t'(`AFU_LINE_BYTES);
    end
  end

  // Each 64-bit word of the line carries its own byte address.
  always_comb begin
    cmd_line.command   = write_ms;
    cmd_line.cmd_type  = cmd_write;
    cmd_line.address   = line_addr;
    cmd_line.size      = 12'(`AFU_LINE_BYTES);
    cmd_line.cu_id     = cu_id_self;
    data_line.cu_id    = cu_id_self;
    data_line.cmd_type = cmd_write;
    for (int k = 0; k < words; k++) begin
      data_line.data_0[k*64 +: 64] = 64'(line_addr + addr_t'(k * 8));
      data_line.data_1[k*64 +: 64] = 64'(line_addr + addr_t'(64 + k * 8));
    end
  end

endmodule

//--- design/resp_tracker.sv
module resp_tracker (
  input  logic                clock,
  input  logic                rstn,
  input  logic                job_start,
  input  afu_pkg::count_t     job_count,
  input  logic                resp_valid,
  input  afu_pkg::resp_code_e resp_code,
  output logic                job_done,
  output afu_pkg::count_t     failed_count
);

  import afu_pkg::*;

  logic   pending;
  count_t resp_count;
  count_t next_count;

  // Count including this cycle's response, so job_done lands one cycle after it.
  assign next_count = resp_count + count_t'(resp_valid);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pending      <= 1'b0;
      resp_count   <= '0;
      failed_count <= '0;
      job_done     <= 1'b0;
    end else begin
      job_done <= 1'b0;
      if (job_start) begin
        pending      <= 1'b1;
        resp_count   <= '0;
        failed_count <= '0;
      end else if (pending) begin
        resp_count <= next_count;
        if (resp_valid && (resp_code == resp_failed)) begin
          failed_count <= failed_count + 1'b1;
        end
        if (next_count == job_count) begin
          job_done <= 1'b1;  // A zero-length job finishes straight away.
          pending  <= 1'b0;
        end
      end
    end
  end

endmodule

//--- sim.f
+incdir+design
design/afu_pkg.sv
design/cmd_buffer.sv
design/cu_control.sv
design/cmd_issue.sv
design/resp_tracker.sv
design/afu_top.sv
sim/afu_tb.sv

//--- sim/afu_tb.sv
`include "afu_settings.svh"

module afu_tb;

  import afu_pkg::*;

  // Ignored WEDs are counted too, which leaves some slack.
  localparam int test_lines = 1 + 10 + 12 + 8 + 3 + 6 + 5 + 2;
  localparam int timeout_cycles = test_lines * 20 + 200;

  logic          clock;
  logic          rstn;
  logic          enabled;
  logic          wed_valid;
  addr_t         wed_address;
  count_t        wed_count;
  logic          host_credit;
  logic          resp_valid;
  tag_t          resp_tag;
  resp_code_e    resp_code;
  logic          busy;
  logic          host_cmd_valid;
  command_line_t host_cmd;
  tag_t          host_cmd_tag;
  data_line_t    host_data;
  logic          job_done;
  count_t        failed_count;

  integer      seed = 32'he4758907;
  int          cycle = 0;
  int          mismatch_count = 0;
  int          other_count = 0;
  int          issued = 0;
  int          returned = 0;
  int          job_len = 0;
  int          line_idx = 0;
  int          resp_sent = 0;  // Responses driven for the current job.
  int          last_resp_cycle = 0;
  addr_t       job_base = '0;
  int unsigned fail_mask = 0;
  logic        hold_credits = 1'b0;
  tag_t        exp_tag = '0;
  int          credit_due_q[$];
  int          resp_due_q[$];
  tag_t        resp_tag_q[$];
  resp_code_e  resp_code_q[$];

  afu_top u_dut (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .wed_valid      (wed_valid),
    .wed_address    (wed_address),
    .wed_count      (wed_count),
    .host_credit    (host_credit),
    .resp_valid     (resp_valid),
    .resp_tag       (resp_tag),
    .resp_code      (resp_code),
    .busy           (busy),
    .host_cmd_valid (host_cmd_valid),
    .host_cmd       (host_cmd),
    .host_cmd_tag   (host_cmd_tag),
    .host_data      (host_data),
    .job_done       (job_done),
    .failed_count   (failed_count)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    while (cycle < timeout_cycles) begin
      @(posedge clock);
      cycle = cycle + 1;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
    $display("Some tests failed");
    $finish;
  end

  function automatic int random_delay(input int max);
    return 1 + int'({$random(seed)} % max);
  endfunction

  // Every 64-bit word of a half holds its own byte address.
  function automatic half_t word_addresses(input addr_t line_addr, input int half);
    half_t h;
    for (int k = 0; k < `AFU_HALF_BITS / 64; k++) begin
      h[k*64 +: 64] = 64'(line_addr + addr_t'(half * 64 + k * 8));
    end
    return h;
  endfunction

  function automatic void reference_line(input addr_t base, input int index,
                                         output command_line_t cmd, output data_line_t data);
    addr_t line_addr;
    line_addr = base + addr_t'(`AFU_RESULT_OFFSET) + addr_t'(index) * addr_t'(`AFU_LINE_BYTES);
    cmd.command   = write_ms;
    cmd.cmd_type  = cmd_write;
    cmd.address   = line_addr;
    cmd.size      = 12'(`AFU_LINE_BYTES);
    cmd.cu_id     = cu_id_self;
    data.cu_id    = cu_id_self;
    data.cmd_type = cmd_write;
    data.data_0   = word_addresses(line_addr, 0);
    data.data_1   = word_addresses(line_addr, 1);
  endfunction

  task automatic report_failure(input string what);
    other_count++;
    $display("Error at time %0t: %s", $time, what);
  endtask

  task automatic check_command(input string name, input command_line_t expected,
                               input command_line_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at time %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_data(input string name, input data_line_t expected,
                            input data_line_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at time %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at time %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at time %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  // Compares each issued command and schedules its credit and response.
  always @(negedge clock) begin : monitor
    command_line_t exp_cmd;
    data_line_t    exp_data;
    resp_code_e    code;
    if (rstn && host_cmd_valid) begin
      issued++;
      code = resp_done;
      if (issued - returned > `AFU_HOST_CREDITS) begin
        report_failure("more commands outstanding than the host granted credits for");
      end
      if (line_idx >= job_len) begin
        report_failure("command issued outside an accepted job");
      end else begin
        reference_line(job_base, line_idx, exp_cmd, exp_data);
        check_command("host_cmd", exp_cmd, host_cmd);
        check_data("host_data", exp_data, host_data);
        if (((fail_mask >> line_idx) & 32'd1) != 32'd0) begin
          code = resp_failed;
        end
        line_idx++;
      end
      check_tag("host_cmd_tag", exp_tag, host_cmd_tag);
      exp_tag = exp_tag + 1'b1;
      credit_due_q.push_back(cycle + random_delay(4));
      resp_due_q.push_back(cycle + random_delay(6));
      resp_tag_q.push_back(host_cmd_tag);
      resp_code_q.push_back(code);
    end
    if (job_done && busy) begin
      report_failure("busy still high in the job_done cycle");
    end
    if (rstn && job_done && job_len == 0) begin
      report_failure("job_done pulsed without an accepted job");
    end
  end

  // Host side: at most one credit and one response per cycle.
  initial begin : host_model
    forever begin
      @(posedge clock);
      #10;
      host_credit = 1'b0;
      resp_valid  = 1'b0;
      if (!hold_credits && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
        credit_due_q.delete(0);
        host_credit = 1'b1;
        returned++;
      end
      if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
        resp_due_q.delete(0);
        resp_valid      = 1'b1;
        resp_tag        = resp_tag_q.pop_front();
        resp_code       = resp_code_q.pop_front();
        resp_sent++;
        last_resp_cycle = cycle;
      end
    end
  end

  task automatic start_wed(input addr_t base, input int count, input int unsigned mask);
    job_base  = base;
    job_len   = count;
    line_idx  = 0;
    resp_sent = 0;
    fail_mask = mask;
    @(posedge clock);
    #10;
    wed_valid   = 1'b1;
    wed_address = base;
    wed_count   = count_t'(count);
    @(negedge clock);
    while (!busy) @(negedge clock);
    @(posedge clock);
    #10;
    wed_valid = 1'b0;
  endtask

  // A WED that the unit is expected to ignore.
  task automatic present_wed(input addr_t base, input int count, input int cycles);
    @(posedge clock);
    #10;
    wed_valid   = 1'b1;
    wed_address = base;
    wed_count   = count_t'(count);
    repeat (cycles) @(posedge clock);
    #10;
    wed_valid = 1'b0;
  endtask

  task automatic wait_done(input int expected_failed);
    @(negedge clock);
    while (!job_done) @(negedge clock);
    // The last response of the job lands one cycle before job_done.
    if (resp_sent != job_len || cycle != last_resp_cycle + 1) begin
      report_failure("job_done did not come one cycle after the last response of the job");
    end
    @(posedge clock);
    if (line_idx != job_len) begin
      report_failure($sformatf("job ended after %0d of %0d commands", line_idx, job_len));
    end
    check_count("failed_count", count_t'(expected_failed), failed_count);
    job_len = 0;
    while (credit_due_q.size() != 0 || resp_due_q.size() != 0) @(posedge clock);
  endtask

  task automatic run_job(input addr_t base, input int count, input int unsigned mask,
                         input int expected_failed);
    start_wed(base, count, mask);
    wait_done(expected_failed);
  endtask

  initial begin
    rstn        = 1'b0;
    enabled     = 1'b1;
    wed_valid   = 1'b0;
    wed_address = '0;
    wed_count   = '0;
    host_credit = 1'b0;
    resp_valid  = 1'b0;
    resp_tag    = '0;
    resp_code   = resp_done;
    repeat (4) @(posedge clock);
    #10;
    if (busy || host_cmd_valid || job_done) begin
      report_failure("outputs not low during reset");
    end
    rstn = 1'b1;

    run_job(64'h1000, 1, 0, 0);
    run_job(64'h2000_0000, 10, 0, 0);

    hold_credits = 1'b1;  // Host keeps its credits for 30 cycles.
    start_wed(64'h3000, 12, 0);
    repeat (30) @(posedge clock);
    if (line_idx != `AFU_HOST_CREDITS) begin
      report_failure("wrong number of commands issued while host credits were withheld");
    end
    hold_credits = 1'b0;
    wait_done(0);

    run_job(64'h4000, 8, 32'b0101_0010, 3);  // Lines 1, 4 and 6 fail.

    @(posedge clock);
    #10;
    enabled = 1'b0;
    present_wed(64'h5000, 3, 6);
    repeat (20) begin
      @(negedge clock);
      if (busy) begin
        report_failure("WED accepted while enabled was low");
      end
    end
    @(posedge clock);
    #10;
    enabled = 1'b1;
    start_wed(64'h6000, 6, 0);
    present_wed(64'h7000, 5, 3);  // Arrives while busy.
    wait_done(0);
    run_job(64'h8000, 2, 0, 0);

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
